// File: design/pipePkg.sv
// Shared widths, instruction codes, control encodings and stage bundles for the
// five-stage RV32I datapath. Every stage and the testbench import from here.
package pipePkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] PC_START  = 32'h0000_0000;
    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    localparam logic [6:0] OP_BRANCH = 7'b110_0011;
    localparam logic [6:0] OP_JAL    = 7'b110_1111;
    localparam logic [2:0] F3_BEQ    = 3'b000;
    localparam logic [2:0] F3_BNE    = 3'b001;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_J = 3'd3,
        IMM_U = 3'd4
    } immSrcT;

    // Source of an execute operand
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } forwardT;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } aluCtrlT;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10,
        RES_IMM = 2'b11
    } resultSrcT;

    typedef struct packed {
        immSrcT immSrc;
    } decodeCtrlT;

    typedef struct packed {
        logic    aluSrcImm;
        aluCtrlT aluCtrl;
        forwardT forwardA;
        forwardT forwardB;
    } execCtrlT;

    // Decode to execute bundle
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pcPlus4;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            op;
        logic [2:0]            funct3;
        logic [XLEN-1:0]       extImm;
        logic [XLEN-1:0]       rd1;
        logic [XLEN-1:0]       rd2;
    } decodeOutT;

    // Execute to memory bundle
    typedef struct packed {
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       writeData;
        logic [XLEN-1:0]       extImm;
        logic [XLEN-1:0]       pcPlus4;
        logic [REG_ADDR_W-1:0] rd;
    } memOutT;

endpackage

// File: design/fetchStage.sv
// Fetch program counter. Advances by 4 each cycle unless stalled and takes the
// execute-stage target when a branch or jal redirects the pipeline.
`timescale 1ns/10ps

module fetchStage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stallF_i,
    input  logic                      redirect_i,
    input  logic [pipePkg::XLEN-1:0]  redirectPc_i,
    output logic [pipePkg::XLEN-1:0]  pcF_o,
    output logic [pipePkg::XLEN-1:0]  pcPlus4F_o
);
    import pipePkg::*;

    logic [XLEN-1:0] pcNext;

    assign pcPlus4F_o = pcF_o + XLEN'(4);

    // Static not-taken, corrected from execute
    assign pcNext = redirect_i ? redirectPc_i : pcPlus4F_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= PC_START;
        end else if (!stallF_i) begin
            pcF_o <= pcNext;
        end
    end

endmodule

// File: design/decodeStage.sv
// Decode stage: instruction register, field extraction for the external
// controller, and immediate extension in the format the controller selects.
`timescale 1ns/10ps

module decodeStage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            stallD_i,
    input  logic                            flushD_i,
    input  logic [pipePkg::XLEN-1:0]        instrF_i,
    input  logic [pipePkg::XLEN-1:0]        pcF_i,
    input  logic [pipePkg::XLEN-1:0]        pcPlus4F_i,
    input  pipePkg::decodeCtrlT             ctrl_i,
    input  logic [pipePkg::XLEN-1:0]        rd1_i,
    input  logic [pipePkg::XLEN-1:0]        rd2_i,
    output logic [pipePkg::REG_ADDR_W-1:0]  rs1D_o,
    output logic [pipePkg::REG_ADDR_W-1:0]  rs2D_o,
    output logic [6:0]                      op_o,
    output logic [2:0]                      funct3_o,
    output logic                            funct7b5_o,
    output logic [pipePkg::REG_ADDR_W-1:0]  rdD_o,
    output pipePkg::decodeOutT              dec_o
);
    import pipePkg::*;

    logic [XLEN-1:0] instrD;
    logic [XLEN-1:0] pcD;
    logic [XLEN-1:0] pcPlus4D;
    logic [XLEN-1:0] extImmD;

    // Flush wins over stall
    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD   <= NOP_INSTR;
            pcD      <= '0;
            pcPlus4D <= '0;
        end else if (!stallD_i) begin
            instrD   <= instrF_i;
            pcD      <= pcF_i;
            pcPlus4D <= pcPlus4F_i;
        end
    end

    assign op_o       = instrD[6:0];
    assign rdD_o      = instrD[11:7];
    assign funct3_o   = instrD[14:12];
    assign rs1D_o     = instrD[19:15];
    assign rs2D_o     = instrD[24:20];
    assign funct7b5_o = instrD[30];

    always_comb begin
        case (ctrl_i.immSrc)
            IMM_I:   extImmD = {{20{instrD[31]}}, instrD[31:20]};
            IMM_S:   extImmD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            IMM_B:   extImmD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            IMM_J:   extImmD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            IMM_U:   extImmD = {instrD[31:12], 12'b0};
            default: extImmD = '0;
        endcase
    end

    always_comb begin
        dec_o.pc      = pcD;
        dec_o.pcPlus4 = pcPlus4D;
        dec_o.rs1     = rs1D_o;
        dec_o.rs2     = rs2D_o;
        dec_o.rd      = rdD_o;
        dec_o.op      = op_o;
        dec_o.funct3  = funct3_o;
        dec_o.extImm  = extImmD;
        // Register file reads of rs1 and rs2
        dec_o.rd1     = rd1_i;
        dec_o.rd2     = rd2_i;
    end

endmodule

// File: design/regFile.sv
// Two-read, one-write register file with x0 tied to zero. A writeback write is
// bypassed to a decode read of the same register in the same cycle.
`timescale 1ns/10ps

module regFile (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [pipePkg::REG_ADDR_W-1:0]  ra1_i,
    input  logic [pipePkg::REG_ADDR_W-1:0]  ra2_i,
    input  logic [pipePkg::REG_ADDR_W-1:0]  wa_i,
    input  logic                            we_i,
    input  logic [pipePkg::XLEN-1:0]        wd_i,
    output logic [pipePkg::XLEN-1:0]        rd1_o,
    output logic [pipePkg::XLEN-1:0]        rd2_o
);
    import pipePkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // x0 check first, then the write-through path
    assign rd1_o = (ra1_i == '0) ? '0 : (we_i && wa_i == ra1_i) ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : (we_i && wa_i == ra2_i) ? wd_i : regs[ra2_i];

endmodule

// File: design/executeStage.sv
// Execute stage: pipeline register, operand forwarding, ALU and resolution of
// beq, bne and jal. A taken branch or jal redirects fetch to pc plus immediate.
`timescale 1ns/10ps

module executeStage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            flushE_i,
    input  pipePkg::execCtrlT               ctrl_i,
    input  pipePkg::decodeOutT              dec_i,
    input  logic [pipePkg::XLEN-1:0]        aluResultM_i,
    input  logic [pipePkg::XLEN-1:0]        forwardDataM_i,
    input  logic [pipePkg::XLEN-1:0]        resultW_i,
    output logic [pipePkg::REG_ADDR_W-1:0]  rs1E_o,
    output logic [pipePkg::REG_ADDR_W-1:0]  rs2E_o,
    output logic [pipePkg::REG_ADDR_W-1:0]  rdE_o,
    output logic                            zeroE_o,
    output logic                            redirect_o,
    output logic [pipePkg::XLEN-1:0]        redirectPc_o,
    output pipePkg::memOutT                 mem_o
);
    import pipePkg::*;

    decodeOutT       decE;
    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] writeDataE;
    logic [XLEN-1:0] aluResultE;
    logic            isBranch;
    logic            isJal;
    logic            branchTaken;

    // No stall here, a bubble comes in through flush
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            decE <= '0;
        end else begin
            decE <= dec_i;
        end
    end

    assign rs1E_o = decE.rs1;
    assign rs2E_o = decE.rs2;
    assign rdE_o  = decE.rd;

    always_comb begin
        case (ctrl_i.forwardA)
            FWD_MEM: srcA = aluResultM_i;
            FWD_WB:  srcA = resultW_i;
            default: srcA = decE.rd1;
        endcase
    end

    // Memory-side value already chosen by the memory result select
    always_comb begin
        case (ctrl_i.forwardB)
            FWD_MEM: writeDataE = forwardDataM_i;
            FWD_WB:  writeDataE = resultW_i;
            default: writeDataE = decE.rd2;
        endcase
    end

    assign srcB = ctrl_i.aluSrcImm ? decE.extImm : writeDataE;

    always_comb begin
        case (ctrl_i.aluCtrl)
            ALU_ADD: aluResultE = srcA + srcB;
            ALU_SUB: aluResultE = srcA - srcB;
            ALU_AND: aluResultE = srcA & srcB;
            ALU_OR:  aluResultE = srcA | srcB;
            ALU_SLT: aluResultE = XLEN'($signed(srcA) < $signed(srcB));
            default: aluResultE = '0;
        endcase
    end

    assign zeroE_o = (aluResultE == '0);

    // Branch compare relies on ALU_SUB from the controller
    assign isBranch    = (decE.op == OP_BRANCH);
    assign isJal       = (decE.op == OP_JAL);
    assign branchTaken = (decE.funct3 == F3_BEQ && zeroE_o) ||
                         (decE.funct3 == F3_BNE && !zeroE_o);

    assign redirect_o   = isJal || (isBranch && branchTaken);
    assign redirectPc_o = decE.pc + decE.extImm;

    always_comb begin
        mem_o.aluResult = aluResultE;
        mem_o.writeData = writeDataE;
        mem_o.extImm    = decE.extImm;
        mem_o.pcPlus4   = decE.pcPlus4;
        mem_o.rd        = decE.rd;
    end

endmodule

// File: design/memWriteback.sv
// Memory and writeback pipeline registers. Builds the memory-stage forward value
// for execute and the final writeback result for the register file.
`timescale 1ns/10ps

module memWriteback (
    input  logic                            clk,
    input  logic                            reset,
    input  pipePkg::memOutT                 mem_i,
    input  pipePkg::resultSrcT              resultSrcM_i,
    input  pipePkg::resultSrcT              resultSrcW_i,
    input  logic [pipePkg::XLEN-1:0]        readDataM_i,
    output logic [pipePkg::XLEN-1:0]        aluResultM_o,
    output logic [pipePkg::XLEN-1:0]        writeDataM_o,
    output logic [pipePkg::REG_ADDR_W-1:0]  rdM_o,
    output logic [pipePkg::XLEN-1:0]        forwardDataM_o,
    output logic [pipePkg::XLEN-1:0]        resultW_o,
    output logic [pipePkg::REG_ADDR_W-1:0]  rdW_o
);
    import pipePkg::*;

    memOutT          memM;
    logic [XLEN-1:0] aluResultW;
    logic [XLEN-1:0] readDataW;
    logic [XLEN-1:0] extImmW;
    logic [XLEN-1:0] pcPlus4W;

    always_ff @(posedge clk) begin
        if (reset) begin
            memM       <= '0;
            aluResultW <= '0;
            readDataW  <= '0;
            extImmW    <= '0;
            pcPlus4W   <= '0;
            rdW_o      <= '0;
        end else begin
            memM       <= mem_i;
            aluResultW <= memM.aluResult;
            readDataW  <= readDataM_i;
            extImmW    <= memM.extImm;
            pcPlus4W   <= memM.pcPlus4;
            rdW_o      <= memM.rd;
        end
    end

    assign aluResultM_o = memM.aluResult;
    assign writeDataM_o = memM.writeData;
    assign rdM_o        = memM.rd;

    // Load data is not ready yet in this stage
    always_comb begin
        case (resultSrcM_i)
            RES_PC4: forwardDataM_o = memM.pcPlus4;
            RES_IMM: forwardDataM_o = memM.extImm;
            default: forwardDataM_o = memM.aluResult;
        endcase
    end

    always_comb begin
        case (resultSrcW_i)
            RES_MEM: resultW_o = readDataW;
            RES_PC4: resultW_o = pcPlus4W;
            RES_IMM: resultW_o = extImmW;
            default: resultW_o = aluResultW;
        endcase
    end

endmodule

// File: design/datapathTop.sv
// Top of the pipelined datapath. Control and hazard decisions come from outside
// through the stall, flush and control inputs, this level only connects stages.
`timescale 1ns/10ps

module datapathTop (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            stallF_i,
    input  logic                            stallD_i,
    input  logic                            flushD_i,
    input  logic                            flushE_i,
    input  logic [pipePkg::XLEN-1:0]        instrF_i,
    input  pipePkg::decodeCtrlT             decCtrl_i,
    input  pipePkg::execCtrlT               execCtrl_i,
    input  pipePkg::resultSrcT              resultSrcM_i,
    input  pipePkg::resultSrcT              resultSrcW_i,
    input  logic                            regWriteW_i,
    input  logic [pipePkg::XLEN-1:0]        readDataM_i,
    output logic [pipePkg::XLEN-1:0]        pcF_o,
    output logic [pipePkg::REG_ADDR_W-1:0]  rs1D_o,
    output logic [pipePkg::REG_ADDR_W-1:0]  rs2D_o,
    output logic [6:0]                      op_o,
    output logic [2:0]                      funct3_o,
    output logic                            funct7b5_o,
    output logic [pipePkg::REG_ADDR_W-1:0]  rdD_o,
    output logic [pipePkg::REG_ADDR_W-1:0]  rs1E_o,
    output logic [pipePkg::REG_ADDR_W-1:0]  rs2E_o,
    output logic [pipePkg::REG_ADDR_W-1:0]  rdE_o,
    output logic                            zeroE_o,
    output logic                            redirect_o,
    output logic [pipePkg::XLEN-1:0]        aluResultM_o,
    output logic [pipePkg::XLEN-1:0]        writeDataM_o,
    output logic [pipePkg::REG_ADDR_W-1:0]  rdM_o,
    output logic [pipePkg::REG_ADDR_W-1:0]  rdW_o,
    output logic [pipePkg::XLEN-1:0]        resultW_o
);
    import pipePkg::*;

    logic [XLEN-1:0] pcPlus4F;
    logic [XLEN-1:0] redirectPc;
    logic [XLEN-1:0] rd1D;
    logic [XLEN-1:0] rd2D;
    logic [XLEN-1:0] forwardDataM;
    decodeOutT       decD;
    memOutT          memE;

    fetchStage i_fetchStage (
        .clk, .reset, .stallF_i,
        .redirect_i(redirect_o), .redirectPc_i(redirectPc),
        .pcF_o, .pcPlus4F_o(pcPlus4F)
    );

    decodeStage i_decodeStage (
        .clk, .reset, .stallD_i, .flushD_i, .instrF_i,
        .pcF_i(pcF_o), .pcPlus4F_i(pcPlus4F), .ctrl_i(decCtrl_i),
        .rd1_i(rd1D), .rd2_i(rd2D),
        .rs1D_o, .rs2D_o, .op_o, .funct3_o, .funct7b5_o, .rdD_o, .dec_o(decD)
    );

    // Written from writeback, read from decode
    regFile i_regFile (
        .clk, .reset, .ra1_i(rs1D_o), .ra2_i(rs2D_o),
        .wa_i(rdW_o), .we_i(regWriteW_i), .wd_i(resultW_o),
        .rd1_o(rd1D), .rd2_o(rd2D)
    );

    executeStage i_executeStage (
        .clk, .reset, .flushE_i, .ctrl_i(execCtrl_i), .dec_i(decD),
        .aluResultM_i(aluResultM_o), .forwardDataM_i(forwardDataM), .resultW_i(resultW_o),
        .rs1E_o, .rs2E_o, .rdE_o, .zeroE_o,
        .redirect_o, .redirectPc_o(redirectPc), .mem_o(memE)
    );

    memWriteback i_memWriteback (
        .clk, .reset, .mem_i(memE), .resultSrcM_i, .resultSrcW_i, .readDataM_i,
        .aluResultM_o, .writeDataM_o, .rdM_o, .forwardDataM_o(forwardDataM),
        .resultW_o, .rdW_o
    );

endmodule

// File: dv/datapath_properties.sv
// Concurrent checks bound into the execute stage and the register file.
// One checker per bound module, so every rule watches live signals.
`timescale 1ns/10ps

module execProperties (
    input logic       clk,
    input logic       reset,
    input logic       redirect,
    input logic [6:0] opE
);
    import pipePkg::*;

    redirectAfterReset: assert property (@(posedge clk) reset |=> !redirect)
        else $error("redirect high in the cycle after reset");

    // Only a branch or jal in execute may steer fetch
    redirectOnlyCtl: assert property (@(posedge clk) disable iff (reset)
        redirect |-> (opE == OP_BRANCH || opE == OP_JAL))
        else $error("redirect with op %h in execute", opE);

endmodule

module regFileProperties (
    input logic                            clk,
    input logic                            reset,
    input logic [pipePkg::REG_ADDR_W-1:0]  ra1,
    input logic [pipePkg::XLEN-1:0]        rd1,
    input logic [pipePkg::REG_ADDR_W-1:0]  ra2,
    input logic [pipePkg::XLEN-1:0]        rd2
);

    zeroRegRead: assert property (@(posedge clk) disable iff (reset)
        ((ra1 == '0) |-> (rd1 == '0)) and ((ra2 == '0) |-> (rd2 == '0)))
        else $error("x0 read returned a nonzero value");

endmodule

bind executeStage execProperties i_execProps (
    .clk, .reset, .redirect(redirect_o), .opE(decE.op)
);

bind regFile regFileProperties i_regProps (
    .clk, .reset, .ra1(ra1_i), .rd1(rd1_o), .ra2(ra2_i), .rd2(rd2_o)
);

// File: dv/datapathTb.sv
// Testbench for the pipelined datapath. Plays the control and hazard units,
// keeps a model register file and checks results at their fixed latencies.
`timescale 1ns/10ps

module datapathTb;
    import pipePkg::*;

    localparam int NUM_RANDOM  = 60;
    localparam int NUM_CONTROL = 12;
    localparam int MAX_CYCLES  = 31 + NUM_RANDOM + 12 + 3 * NUM_CONTROL + 20 + 100;

    // What the controller knows about one instruction in one stage
    typedef struct packed {
        logic            valid;
        logic            regWrite;
        logic            chkAlu;
        logic            isCtl;
        logic            expRedirect;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic            aluSrcImm;
        aluCtrlT         aluCtrl;
        resultSrcT       resSrc;
        immSrcT          immSrc;
        logic [31:0]     instr;
        logic [XLEN-1:0] expAlu;
        logic [XLEN-1:0] expWd;
        logic [XLEN-1:0] expRes;
        logic [XLEN-1:0] target;
    } slotT;

    logic                  clk;
    logic                  reset;
    logic                  stallF_i;
    logic                  stallD_i;
    logic                  flushD_i;
    logic                  flushE_i;
    logic [XLEN-1:0]       instrF_i;
    decodeCtrlT            decCtrl_i;
    execCtrlT              execCtrl_i;
    resultSrcT             resultSrcM_i;
    resultSrcT             resultSrcW_i;
    logic                  regWriteW_i;
    logic [XLEN-1:0]       readDataM_i;
    logic [XLEN-1:0]       pcF_o;
    logic [4:0]            rs1D_o;
    logic [4:0]            rs2D_o;
    logic [6:0]            op_o;
    logic [2:0]            funct3_o;
    logic                  funct7b5_o;
    logic [4:0]            rdD_o;
    logic [4:0]            rs1E_o;
    logic [4:0]            rs2E_o;
    logic [4:0]            rdE_o;
    logic                  zeroE_o;
    logic                  redirect_o;
    logic [XLEN-1:0]       aluResultM_o;
    logic [XLEN-1:0]       writeDataM_o;
    logic [4:0]            rdM_o;
    logic [4:0]            rdW_o;
    logic [XLEN-1:0]       resultW_o;

    logic [XLEN-1:0] modelRegs [32];
    slotT            fSlot;
    slotT            dSlot;
    slotT            eSlot;
    slotT            mSlot;
    slotT            wSlot;
    logic            prevStall;
    logic            flushPending;
    logic [XLEN-1:0] pcModel;
    logic [31:0]     rngState;
    int              errors;
    int              checks;
    int              cycles;

    datapathTop i_datapathTop (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Reference ALU from the instruction semantics
    function automatic logic [XLEN-1:0] aluModel(input aluCtrlT c, input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
        case (c)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_SLT: return {31'b0, $signed(a) < $signed(b)};
            default: return '0;
        endcase
    endfunction

    // Hazard unit, youngest producer first
    function automatic forwardT fwdSel(input logic [4:0] rs);
        if (rs != 5'd0 && mSlot.regWrite && mSlot.rd == rs) begin
            return FWD_MEM;
        end
        if (rs != 5'd0 && wSlot.regWrite && wSlot.rd == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        errors++;
        $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    // Advance the controller's stage slots and drive every control for the cycle
    task automatic drive(input slotT s, input logic [31:0] instr, input logic stall,
                         input logic flushReq);
        wSlot = mSlot;
        mSlot = eSlot;
        if (prevStall) begin
            eSlot = '0;
        end else begin
            eSlot = dSlot;
            dSlot = fSlot;
        end
        fSlot = s;
        instrF_i = instr;
        decCtrl_i.immSrc     = dSlot.immSrc;
        execCtrl_i.aluSrcImm = eSlot.aluSrcImm;
        execCtrl_i.aluCtrl   = eSlot.aluCtrl;
        execCtrl_i.forwardA  = fwdSel(eSlot.rs1);
        execCtrl_i.forwardB  = fwdSel(eSlot.rs2);
        resultSrcM_i = mSlot.resSrc;
        resultSrcW_i = wSlot.resSrc;
        regWriteW_i  = wSlot.regWrite;
        stallF_i = stall;
        stallD_i = stall;
        flushE_i = stall | eSlot.expRedirect;
        flushD_i = flushReq | eSlot.expRedirect;
        prevStall = stall;
    endtask

    task automatic bubble(input logic [31:0] instr, input logic stall, input logic flushReq);
        @(negedge clk);
        drive('0, instr, stall, flushReq);
    endtask

    // kind 0 addi, 1 add, 2 sub, 3 and, 4 or, 5 slt
    task automatic issueAlu(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [11:0] imm);
        slotT        s;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        @(negedge clk);
        s = '0;
        s.valid = 1'b1;
        s.regWrite = 1'b1;
        s.chkAlu = 1'b1;
        s.rd = rd;
        s.rs1 = rs1;
        s.rs2 = rs2;
        a = modelRegs[rs1];
        b = modelRegs[rs2];
        case (kind)
            0: begin
                instr = {imm, rs1, 3'b000, rd, 7'h13};
                s.aluSrcImm = 1'b1;
                s.rs2 = 5'd0;
                b = {{20{imm[11]}}, imm};
            end
            1: instr = {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
            2: begin
                instr = {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
                s.aluCtrl = ALU_SUB;
            end
            3: begin
                instr = {7'h00, rs2, rs1, 3'b111, rd, 7'h33};
                s.aluCtrl = ALU_AND;
            end
            4: begin
                instr = {7'h00, rs2, rs1, 3'b110, rd, 7'h33};
                s.aluCtrl = ALU_OR;
            end
            default: begin
                instr = {7'h00, rs2, rs1, 3'b010, rd, 7'h33};
                s.aluCtrl = ALU_SLT;
            end
        endcase
        s.instr = instr;
        s.expWd = b;
        s.expAlu = aluModel(s.aluCtrl, a, b);
        s.expRes = s.expAlu;
        if (rd != 5'd0) begin
            modelRegs[rd] = s.expAlu;
        end
        drive(s, instr, 1'b0, 1'b0);
    endtask

    // Two bubbles follow so no wrong-path work enters the model
    task automatic issueBranch(input logic isBne, input logic [4:0] rs1, input logic [4:0] rs2,
                               input logic [12:0] imm);
        slotT        s;
        logic [31:0] instr;
        logic        equal;
        @(negedge clk);
        s = '0;
        s.valid = 1'b1;
        s.isCtl = 1'b1;
        s.chkAlu = 1'b1;
        s.rs1 = rs1;
        s.rs2 = rs2;
        s.immSrc = IMM_B;
        s.aluCtrl = ALU_SUB;
        s.expAlu = modelRegs[rs1] - modelRegs[rs2];
        s.expWd = modelRegs[rs2];
        equal = (modelRegs[rs1] == modelRegs[rs2]);
        s.expRedirect = isBne ? !equal : equal;
        s.target = pcModel + {{19{imm[12]}}, imm};
        instr = {imm[12], imm[10:5], rs2, rs1, isBne ? F3_BNE : F3_BEQ, imm[4:1], imm[11],
                 OP_BRANCH};
        s.instr = instr;
        drive(s, instr, 1'b0, 1'b0);
        bubble(NOP_INSTR, 1'b0, 1'b0);
        bubble(NOP_INSTR, 1'b0, 1'b0);
    endtask

    task automatic issueJal(input logic [4:0] rd, input logic [20:0] imm);
        slotT        s;
        logic [31:0] instr;
        @(negedge clk);
        s = '0;
        s.valid = 1'b1;
        s.regWrite = 1'b1;
        s.isCtl = 1'b1;
        s.expRedirect = 1'b1;
        s.rd = rd;
        s.immSrc = IMM_J;
        s.resSrc = RES_PC4;
        s.target = pcModel + {{11{imm[20]}}, imm};
        s.expRes = pcModel + 32'd4;
        if (rd != 5'd0) begin
            modelRegs[rd] = s.expRes;
        end
        instr = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
        s.instr = instr;
        drive(s, instr, 1'b0, 1'b0);
        bubble(NOP_INSTR, 1'b0, 1'b0);
        bubble(NOP_INSTR, 1'b0, 1'b0);
    endtask

    // Compare every stage with the controller's view of the pipeline
    task automatic checkStages();
        logic [31:0] gotFields;
        logic [31:0] expFields;
        checks++;
        if (pcF_o !== pcModel) begin
            reportMismatch("pcF_o", pcF_o, pcModel);
        end
        // Static not-taken unless a control transfer resolves in execute
        if (!stallF_i) begin
            pcModel = (eSlot.isCtl && eSlot.expRedirect) ? eSlot.target : pcModel + 32'd4;
        end
        if (dSlot.valid) begin
            checks++;
            gotFields = {6'b0, rs1D_o, rs2D_o, rdD_o, funct3_o, funct7b5_o, op_o};
            expFields = {6'b0, dSlot.instr[19:15], dSlot.instr[24:20], dSlot.instr[11:7],
                         dSlot.instr[14:12], dSlot.instr[30], dSlot.instr[6:0]};
            if (gotFields !== expFields) begin
                reportMismatch("decode fields", gotFields, expFields);
            end
        end
        if (eSlot.valid) begin
            checks++;
            gotFields = {17'b0, rs1E_o, rs2E_o, rdE_o};
            expFields = {17'b0, eSlot.instr[19:15], eSlot.instr[24:20], eSlot.instr[11:7]};
            if (gotFields !== expFields) begin
                reportMismatch("execute register indexes", gotFields, expFields);
            end
            if (eSlot.isCtl) begin
                checks++;
                if (redirect_o !== eSlot.expRedirect) begin
                    reportMismatch("redirect_o", {31'b0, redirect_o},
                                   {31'b0, eSlot.expRedirect});
                end
            end
            if (eSlot.chkAlu) begin
                checks++;
                if (zeroE_o !== (eSlot.expAlu == 32'd0)) begin
                    reportMismatch("zeroE_o", {31'b0, zeroE_o},
                                   {31'b0, eSlot.expAlu == 32'd0});
                end
            end
        end
        if (mSlot.valid) begin
            checks++;
            if (rdM_o !== mSlot.instr[11:7]) begin
                reportMismatch("rdM_o", {27'b0, rdM_o}, {27'b0, mSlot.instr[11:7]});
            end
            if (mSlot.chkAlu) begin
                checks++;
                if (aluResultM_o !== mSlot.expAlu) begin
                    reportMismatch("aluResultM_o", aluResultM_o, mSlot.expAlu);
                end
            end
            if (mSlot.chkAlu && !mSlot.aluSrcImm) begin
                checks++;
                if (writeDataM_o !== mSlot.expWd) begin
                    reportMismatch("writeDataM_o", writeDataM_o, mSlot.expWd);
                end
            end
        end
        if (wSlot.valid) begin
            checks++;
            if (rdW_o !== wSlot.instr[11:7]) begin
                reportMismatch("rdW_o", {27'b0, rdW_o}, {27'b0, wSlot.instr[11:7]});
            end
            if (wSlot.regWrite) begin
                checks++;
                if (resultW_o !== wSlot.expRes) begin
                    reportMismatch("resultW_o", resultW_o, wSlot.expRes);
                end
            end
        end
        if (flushPending) begin
            checks++;
            if (op_o !== NOP_INSTR[6:0]) begin
                reportMismatch("op_o after flush", {25'b0, op_o}, {25'b0, NOP_INSTR[6:0]});
            end
        end
        flushPending = flushD_i;
    endtask

    // Compare process, samples values that settled during the cycle
    always @(posedge clk) begin
        if (!reset) begin
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
                $display("RESULT: FAIL");
                $finish;
            end else begin
                checkStages();
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        rngState = 32'h5d1f59a0;
        errors = 0;
        checks = 0;
        cycles = 0;
        prevStall = 1'b0;
        flushPending = 1'b0;
        pcModel = PC_START;
        fSlot = '0;
        dSlot = '0;
        eSlot = '0;
        mSlot = '0;
        wSlot = '0;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        stallF_i = 1'b0;
        stallD_i = 1'b0;
        flushD_i = 1'b0;
        flushE_i = 1'b0;
        instrF_i = NOP_INSTR;
        decCtrl_i = '0;
        execCtrl_i = '0;
        resultSrcM_i = RES_ALU;
        resultSrcW_i = RES_ALU;
        regWriteW_i = 1'b0;
        readDataM_i = '0;
        reset = 1'b1;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        // Independent loads of every register
        for (int r = 1; r < 32; r++) begin
            rnd = nextRand();
            issueAlu(0, 5'(r), 5'd0, 5'd0, rnd[11:0]);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = nextRand();
            issueAlu(int'(rnd[2:0]) % 6, rnd[7:3], rnd[12:8], rnd[17:13], rnd[29:18]);
        end

        // Forwarding from memory and writeback, then a same-cycle regfile bypass
        issueAlu(1, 5'd3, 5'd1, 5'd2, 12'd0);
        issueAlu(2, 5'd4, 5'd3, 5'd3, 12'd0);
        issueAlu(3, 5'd5, 5'd4, 5'd3, 12'd0);
        issueAlu(0, 5'd6, 5'd5, 5'd0, 12'h7ff);
        bubble(NOP_INSTR, 1'b0, 1'b0);
        bubble(NOP_INSTR, 1'b0, 1'b0);
        issueAlu(4, 5'd7, 5'd6, 5'd0, 12'd0);
        issueAlu(5, 5'd0, 5'd1, 5'd2, 12'd0);
        issueAlu(1, 5'd8, 5'd0, 5'd0, 12'd0);

        for (int i = 0; i < NUM_CONTROL; i++) begin
            rnd = nextRand();
            case (rnd[1:0])
                2'd0: issueBranch(1'b0, rnd[16:12], rnd[16:12], {3'b0, rnd[9:2], 2'b0});
                2'd1: issueBranch(1'b1, rnd[16:12], rnd[16:12], {3'b0, rnd[9:2], 2'b0});
                2'd2: issueBranch(rnd[11], rnd[16:12], rnd[21:17], {3'b0, rnd[9:2], 2'b0});
                default: issueJal(rnd[16:12], {9'b0, rnd[11:2], 2'b0});
            endcase
            issueAlu(1, rnd[26:22], rnd[16:12], rnd[21:17], 12'd0);
        end

        // Stall with a live instruction in decode, then a decode flush
        issueAlu(1, 5'd9, 5'd1, 5'd2, 12'd0);
        bubble(NOP_INSTR, 1'b1, 1'b0);
        issueAlu(2, 5'd10, 5'd9, 5'd1, 12'd0);
        bubble(32'h0000_0033, 1'b0, 1'b1);
        repeat (6) bubble(NOP_INSTR, 1'b0, 1'b0);

        @(negedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
design/pipePkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/regFile.sv
design/executeStage.sv
design/memWriteback.sv
design/datapathTop.sv
dv/datapath_properties.sv
dv/datapathTb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f project.f --top-module datapathTb \
		-Mdir build -o simv
	./build/simv | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf build sim.log
